// File: hw/tester_pkg.sv
`default_nettype none

package tester_pkg;

	//////////////////////////////////////////////////
	// Host words and codes.
	//////////////////////////////////////////////////

	// Width of one host word.
	localparam int WORD_W = 32;

	typedef logic [WORD_W-1:0] word_t;

	// Command and reply codes sit in the low byte of a word.
	typedef logic [7:0] code_t;

	// Commands from the host.
	localparam code_t CMD_VECTOR_HDR   = 8'h11;
	localparam code_t CMD_CYCLE_CONFIG = 8'h22;
	localparam code_t CMD_EXECUTE      = 8'h33;

	// Replies to the host.
	localparam code_t RPL_ACK          = 8'hA5;
	localparam code_t RPL_UNKNOWN_CODE = 8'hE1;
	localparam code_t RPL_NO_VECTORS   = 8'hE2;
	localparam code_t RPL_STORE_FULL   = 8'hE3;

	//////////////////////////////////////////////////
	// Cycle configuration.
	//////////////////////////////////////////////////

	// Position inside one test cycle, in clock cycles.
	typedef logic [7:0] edge_t;

	// Field positions inside the config word.
	localparam int LEAD_LSB  = 8;
	localparam int TRAIL_LSB = 16;
	localparam int LEN_LSB   = 24;

	// Values after reset.
	localparam edge_t DEF_LEAD  = 8'd6;
	localparam edge_t DEF_TRAIL = 8'd9;
	localparam edge_t DEF_LEN   = 8'd10;

endpackage

`default_nettype wire

// File: hw/cmd_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module cmd_sequencer
	import tester_pkg::*;
(
	input  logic  CLK,
	input  logic  rst,
	input  logic  rx_valid,
	input  word_t rx_data,
	output logic  rx_ready,
	output logic  tx_valid,
	output word_t tx_data,
	input  logic  tx_ready,
	output logic  wr_en,
	output word_t wr_data,
	output logic  rd_req,
	output logic  rewind,
	input  logic  rd_valid,
	input  logic  more_to_read,
	input  logic  full,
	output logic  cfg_load,
	output logic  run,
	input  logic  stage_req,
	input  logic  cycle_end,
	output logic  stage_load
);

	localparam int PAD_W = WORD_W - $bits(code_t);

	typedef enum logic [3:0] {
		ST_IDLE,
		ST_DECODE,
		ST_VEC_WAIT,
		ST_VEC_TAKE,
		ST_PREFETCH,
		ST_PRIME,
		ST_RUN,
		ST_DONE,
		ST_REPLY
	} state_t;

	state_t state;
	code_t  cmd_code;
	code_t  rpl_code;
	// Header acknowledged, next word is a vector.
	logic   vec_next;
	// Next vector has been read and waits for the cycle boundary.
	logic   next_ready;

	assign cmd_code = rx_data[$bits(code_t)-1:0];

	//////////////////////////////////////////////////
	// State register.
	//////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			state      <= ST_IDLE;
			run        <= 1'b0;
			rpl_code   <= RPL_ACK;
			vec_next   <= 1'b0;
			next_ready <= 1'b0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (rx_valid) begin
						state <= ST_DECODE;
					end
				end
				ST_DECODE: begin
					// Word is taken here; most codes answer straight away.
					state <= ST_REPLY;
					case (cmd_code)
						CMD_VECTOR_HDR: begin
							rpl_code <= full ? RPL_STORE_FULL : RPL_ACK;
							vec_next <= !full;
						end
						CMD_CYCLE_CONFIG: begin
							rpl_code <= RPL_ACK;
						end
						CMD_EXECUTE: begin
							if (more_to_read) begin
								state <= ST_PREFETCH;
							end else begin
								rpl_code <= RPL_NO_VECTORS;
							end
						end
						default: begin
							rpl_code <= RPL_UNKNOWN_CODE;
						end
					endcase
				end
				ST_VEC_WAIT: begin
					if (rx_valid) begin
						state <= ST_VEC_TAKE;
					end
				end
				ST_VEC_TAKE: begin
					rpl_code <= RPL_ACK;
					state    <= ST_REPLY;
				end
				ST_PREFETCH: begin
					state <= ST_PRIME;
				end
				ST_PRIME: begin
					// First vector is staged, start the timer.
					if (rd_valid) begin
						run        <= 1'b1;
						next_ready <= 1'b0;
						state      <= ST_RUN;
					end
				end
				ST_RUN: begin
					if (rd_valid) begin
						next_ready <= 1'b1;
					end
					if (cycle_end) begin
						if (next_ready) begin
							next_ready <= 1'b0;
						end else begin
							// Nothing left to stage, this was the final test cycle.
							run   <= 1'b0;
							state <= ST_DONE;
						end
					end
				end
				ST_DONE: begin
					rpl_code <= RPL_ACK;
					state    <= ST_REPLY;
				end
				ST_REPLY: begin
					if (tx_ready) begin
						state    <= vec_next ? ST_VEC_WAIT : ST_IDLE;
						vec_next <= 1'b0;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Strobes.
	//////////////////////////////////////////////////

	always_comb begin
		rx_ready   = 1'b0;
		wr_en      = 1'b0;
		rd_req     = 1'b0;
		rewind     = 1'b0;
		cfg_load   = 1'b0;
		stage_load = 1'b0;
		case (state)
			ST_DECODE: begin
				rx_ready = 1'b1;
				cfg_load = (cmd_code == CMD_CYCLE_CONFIG);
			end
			ST_VEC_TAKE: begin
				rx_ready = 1'b1;
				wr_en    = 1'b1;
			end
			ST_PREFETCH: begin
				rd_req = 1'b1;
			end
			ST_PRIME: begin
				stage_load = rd_valid;
			end
			ST_RUN: begin
				// Fetch one ahead at the start of each test cycle.
				rd_req     = stage_req && more_to_read;
				stage_load = cycle_end && next_ready;
			end
			ST_DONE: begin
				// Soft reset of the read side.
				rewind = 1'b1;
			end
			default: begin
			end
		endcase
	end

	assign tx_valid = (state == ST_REPLY);
	assign tx_data  = {{PAD_W{1'b0}}, rpl_code};
	assign wr_data  = rx_data;

	// Reply word must not change while the host holds it off.
	a_tx_hold: assert property (@(posedge CLK) disable iff (rst)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_data));

endmodule

`default_nettype wire

// File: hw/vector_store.sv
`timescale 1ns/1ps
`default_nettype none

module vector_store
	import tester_pkg::*;
#(
	parameter int SIG_W = 16,
	parameter int DEPTH = 8
) (
	input  logic             CLK,
	input  logic             rst,
	input  logic             wr_en,
	input  word_t            wr_data,
	input  logic             rd_req,
	input  logic             rewind,
	output logic [SIG_W-1:0] rd_data,
	output logic             rd_valid,
	output logic             more_to_read,
	output logic             full
);

	// Pointers count up to DEPTH, so one bit wider than the index.
	localparam int PTR_W  = $clog2(DEPTH + 1);
	localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	logic [SIG_W-1:0] mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// Write side, cleared only by a hard reset.
	always_ff @(posedge CLK) begin
		if (rst) begin
			wr_ptr <= '0;
		end else if (wr_en && !full) begin
			wr_ptr <= wr_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (wr_en && !full) begin
			mem[wr_ptr[ADDR_W-1:0]] <= wr_data[SIG_W-1:0];
		end
	end

	// Read side, rewound at the end of every run.
	always_ff @(posedge CLK) begin
		if (rst || rewind) begin
			rd_ptr <= '0;
		end else if (rd_req) begin
			rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (rst) begin
			rd_valid <= 1'b0;
		end else begin
			rd_valid <= rd_req;
		end
	end

	// Data lands one cycle after the request.
	always_ff @(posedge CLK) begin
		if (rd_req) begin
			rd_data <= mem[rd_ptr[ADDR_W-1:0]];
		end
	end

	assign more_to_read = (rd_ptr < wr_ptr);
	assign full         = (wr_ptr == PTR_W'(DEPTH));

	// Sequencer must turn a header away once the store is full.
	a_no_overflow: assert property (@(posedge CLK) disable iff (rst) full |-> !wr_en);

endmodule

`default_nettype wire

// File: hw/cycle_timer.sv
`timescale 1ns/1ps
`default_nettype none

module cycle_timer
	import tester_pkg::*;
(
	input  logic  CLK,
	input  logic  rst,
	input  logic  cfg_load,
	input  word_t cfg_word,
	input  logic  run,
	output logic  cycle_end,
	output logic  stage_req,
	output logic  cs_n,
	output logic  counter_clk
);

	localparam int EDGE_W = $bits(edge_t);

	edge_t lead;
	edge_t trail;
	edge_t len;
	edge_t count;

	//////////////////////////////////////////////////
	// Configuration.
	//////////////////////////////////////////////////

	always_ff @(posedge CLK) begin
		if (rst) begin
			lead  <= DEF_LEAD;
			trail <= DEF_TRAIL;
			len   <= DEF_LEN;
		end else if (cfg_load) begin
			lead  <= cfg_word[LEAD_LSB +: EDGE_W];
			trail <= cfg_word[TRAIL_LSB +: EDGE_W];
			len   <= cfg_word[LEN_LSB +: EDGE_W];
		end
	end

	//////////////////////////////////////////////////
	// Test-cycle counter.
	//////////////////////////////////////////////////

	// Held at zero whenever no run is active.
	always_ff @(posedge CLK) begin
		if (rst || !run) begin
			count <= '0;
		end else if (count == len - 1'b1) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	// Fetch the next vector at the top of the cycle.
	assign stage_req = run && (count == '0);

	// Last clock of the cycle; pins change on the next edge.
	assign cycle_end = run && (count == len - 1'b1);

	// Memory select window, low from lead up to trail.
	assign cs_n = !(run && (count >= lead) && (count < trail));

	// One address step per test cycle, just before the boundary.
	assign counter_clk = run && (count == len - 8'd2);

	// Host must send an ordered configuration.
	a_cfg_order: assert property (@(posedge CLK) disable iff (rst)
		cfg_load |=> (lead < trail) && (trail < len));

endmodule

`default_nettype wire

// File: hw/signal_driver.sv
`timescale 1ns/1ps
`default_nettype none

module signal_driver #(
	parameter int SIG_W = 16
) (
	input  logic             CLK,
	input  logic             rst,
	input  logic             stage_load,
	input  logic [SIG_W-1:0] stage_data,
	input  logic             apply,
	output logic [SIG_W-1:0] signals
);

	// Next vector, waiting for the cycle boundary.
	logic [SIG_W-1:0] staged;

	// Load side.
	always_ff @(posedge CLK) begin
		if (stage_load) begin
			staged <= stage_data;
		end
	end

	// Transfer side, drives the device pins.
	// Old staged value moves out on the same edge a new one arrives.
	always_ff @(posedge CLK) begin
		if (rst) begin
			signals <= '0;
		end else if (apply) begin
			signals <= staged;
		end
	end

endmodule

`default_nettype wire

// File: hw/tester_top.sv
`timescale 1ns/1ps
`default_nettype none

module tester_top
	import tester_pkg::*;
#(
	parameter int SIG_W = 16,
	parameter int DEPTH = 8
) (
	input  logic             CLK,
	input  logic             rst,
	input  logic             rx_valid,
	input  word_t            rx_data,
	output logic             rx_ready,
	output logic             tx_valid,
	output word_t            tx_data,
	input  logic             tx_ready,
	output logic [SIG_W-1:0] signals,
	output logic             cs_n,
	output logic             counter_clk
);

	//////////////////////////////////////////////////
	// Internal wires.
	//////////////////////////////////////////////////

	// Store interface.
	logic             wr_en;
	word_t            wr_data;
	logic             rd_req;
	logic             rewind;
	logic [SIG_W-1:0] rd_data;
	logic             rd_valid;
	logic             more_to_read;
	logic             full;

	// Timer and driver control.
	logic             cfg_load;
	logic             run;
	logic             cycle_end;
	logic             stage_req;
	logic             stage_load;

	cmd_sequencer u_cmd_sequencer (
		.CLK          (CLK),
		.rst          (rst),
		.rx_valid     (rx_valid),
		.rx_data      (rx_data),
		.rx_ready     (rx_ready),
		.tx_valid     (tx_valid),
		.tx_data      (tx_data),
		.tx_ready     (tx_ready),
		.wr_en        (wr_en),
		.wr_data      (wr_data),
		.rd_req       (rd_req),
		.rewind       (rewind),
		.rd_valid     (rd_valid),
		.more_to_read (more_to_read),
		.full         (full),
		.cfg_load     (cfg_load),
		.run          (run),
		.stage_req    (stage_req),
		.cycle_end    (cycle_end),
		.stage_load   (stage_load)
	);

	vector_store #(
		.SIG_W (SIG_W),
		.DEPTH (DEPTH)
	) u_vector_store (
		.CLK          (CLK),
		.rst          (rst),
		.wr_en        (wr_en),
		.wr_data      (wr_data),
		.rd_req       (rd_req),
		.rewind       (rewind),
		.rd_data      (rd_data),
		.rd_valid     (rd_valid),
		.more_to_read (more_to_read),
		.full         (full)
	);

	// Config word is read straight off the receive channel.
	cycle_timer u_cycle_timer (
		.CLK         (CLK),
		.rst         (rst),
		.cfg_load    (cfg_load),
		.cfg_word    (rx_data),
		.run         (run),
		.cycle_end   (cycle_end),
		.stage_req   (stage_req),
		.cs_n        (cs_n),
		.counter_clk (counter_clk)
	);

	signal_driver #(
		.SIG_W (SIG_W)
	) u_signal_driver (
		.CLK        (CLK),
		.rst        (rst),
		.stage_load (stage_load),
		.stage_data (rd_data),
		.apply      (cycle_end),
		.signals    (signals)
	);

endmodule

`default_nettype wire

// File: sim/tb_tester.sv
`timescale 1ns/1ps
`default_nettype none

module tb_tester
	import tester_pkg::*;
();

	localparam int SIG_W   = 16;
	localparam int DEPTH   = 8;
	localparam int MAX_LEN = 40;
	localparam int SEED    = 32'h92f7c571;
	// Every vector at the longest cycle, plus command traffic.
	localparam int TIMEOUT = DEPTH * MAX_LEN + 2000;

	logic             CLK;
	logic             rst;
	logic             rx_valid;
	word_t            rx_data;
	logic             rx_ready;
	logic             tx_valid;
	word_t            tx_data;
	logic             tx_ready;
	logic [SIG_W-1:0] signals;
	logic             cs_n;
	logic             counter_clk;

	// Host-side model of the store.
	word_t            vec_words [DEPTH];
	logic [SIG_W-1:0] stored_q [$];
	bit               vec_phase;

	// Monitor results.
	logic [SIG_W-1:0] seen_q [$];
	logic [SIG_W-1:0] last_sig;
	int               low_q [$];
	int               low_cnt;
	int               cycle_cnt;

	tester_top #(
		.SIG_W (SIG_W),
		.DEPTH (DEPTH)
	) u_tester_top (
		.CLK         (CLK),
		.rst         (rst),
		.rx_valid    (rx_valid),
		.rx_data     (rx_data),
		.rx_ready    (rx_ready),
		.tx_valid    (tx_valid),
		.tx_data     (tx_data),
		.tx_ready    (tx_ready),
		.signals     (signals),
		.cs_n        (cs_n),
		.counter_clk (counter_clk)
	);

	always #50 CLK = ~CLK;

	//////////////////////////////////////////////////
	// Reference model and checks.
	//////////////////////////////////////////////////

	// Reply the host should see for one word.
	function automatic code_t expected_reply(input word_t w, input bit vec_word, input int count);
		code_t code;
		code = w[7:0];
		// A vector word is always taken.
		if (vec_word) return RPL_ACK;
		case (code)
			CMD_VECTOR_HDR:   return (count >= DEPTH) ? RPL_STORE_FULL : RPL_ACK;
			CMD_CYCLE_CONFIG: return RPL_ACK;
			CMD_EXECUTE:      return (count == 0) ? RPL_NO_VECTORS : RPL_ACK;
			default:          return RPL_UNKNOWN_CODE;
		endcase
	endfunction

	task automatic fail_run();
		$display("*** FAILED ***");
		$fatal(1, "Stopping at first error");
	endtask

	task automatic check_code(input string name, input code_t exp, input code_t act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_word(input string name, input word_t exp, input word_t act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_vec(input string name, input logic [SIG_W-1:0] exp,
			input logic [SIG_W-1:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s expected %h actual %h", name, exp, act);
			fail_run();
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("[FAIL] %s expected %0d actual %0d", name, exp, act);
			fail_run();
		end
	endtask

	//////////////////////////////////////////////////
	// Host channel.
	//////////////////////////////////////////////////

	// Hold the word until ready is seen with valid.
	task automatic drive_word(input word_t w);
		@(posedge CLK);
		rx_valid <= 1'b1;
		rx_data  <= w;
		@(negedge CLK);
		while (!rx_ready) @(negedge CLK);
		@(posedge CLK);
		rx_valid <= 1'b0;
	endtask

	// Wait for a reply and accept it after a short random hold-off.
	task automatic take_reply(output word_t w);
		int hold;
		@(negedge CLK);
		while (!tx_valid) @(negedge CLK);
		w    = tx_data;
		hold = $urandom_range(0, 2);
		repeat (hold) @(posedge CLK);
		@(posedge CLK);
		tx_ready <= 1'b1;
		@(posedge CLK);
		tx_ready <= 1'b0;
	endtask

	task automatic send_command(input string name, input word_t w);
		code_t exp;
		word_t rpl;
		exp = expected_reply(w, vec_phase, stored_q.size());
		drive_word(w);
		take_reply(rpl);
		check_code(name, exp, rpl[7:0]);
		// Upper bytes of a reply word are zero.
		check_word({name, " reply word"}, word_t'(exp), rpl);
		// Track what the store should now hold.
		if (vec_phase) begin
			stored_q.push_back(w[SIG_W-1:0]);
			vec_phase = 1'b0;
		end else if (w[7:0] == CMD_VECTOR_HDR && exp == RPL_ACK) begin
			vec_phase = 1'b1;
		end
	endtask

	// Nonzero and distinct vectors, so every apply shows as a change on the pins.
	task automatic make_vectors();
		word_t w;
		bit    fresh;
		for (int i = 0; i < DEPTH; i++) begin
			do begin
				w     = $urandom;
				fresh = (w[SIG_W-1:0] != '0);
				for (int j = 0; j < i; j++) begin
					if (vec_words[j][SIG_W-1:0] == w[SIG_W-1:0]) fresh = 1'b0;
				end
			end while (!fresh);
			vec_words[i] = w;
		end
	endtask

	// Execute and check pins, window width and pulse count.
	task automatic run_and_check(input string name, input edge_t lead, input edge_t trail);
		int n;
		seen_q.delete();
		low_q.delete();
		low_cnt = 0;
		send_command({name, " execute"}, {24'd0, CMD_EXECUTE});
		n = stored_q.size();
		check_count({name, " counter_clk pulses"}, n, low_q.size());
		check_count({name, " applied vectors"}, n, seen_q.size());
		for (int i = 0; i < n; i++) begin
			check_vec({name, " vector order"}, stored_q[i], seen_q[i]);
			check_count({name, " cs_n low cycles"}, int'(trail) - int'(lead), low_q[i]);
		end
		@(negedge CLK);
		if (cs_n !== 1'b1 || counter_clk !== 1'b0) begin
			$display("Chip select or counter pulse still active after the %s", name);
			fail_run();
		end
	endtask

	//////////////////////////////////////////////////
	// Monitor and watchdog.
	//////////////////////////////////////////////////

	// Outputs change on the rising edge, so look at them on the falling one.
	always @(negedge CLK) begin
		if (!rst) begin
			if (signals !== last_sig) begin
				seen_q.push_back(signals);
				last_sig = signals;
			end
			if (!cs_n) low_cnt++;
			// Last low count is never later than the pulse, so the pulse ends one test cycle.
			if (counter_clk) begin
				low_q.push_back(low_cnt);
				low_cnt = 0;
			end
		end
	end

	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT) begin
			$display("Timeout after %0d cycles with no end of test", cycle_cnt);
			$display("*** FAILED ***");
			$fatal(1, "Watchdog expired");
		end
	end

	//////////////////////////////////////////////////
	// Test sequence.
	//////////////////////////////////////////////////

	initial begin
		int    len_i;
		int    lead_i;
		int    trail_i;
		edge_t cfg_lead;
		edge_t cfg_trail;
		edge_t cfg_len;
		CLK       = 1'b0;
		rst       = 1'b1;
		rx_valid  = 1'b0;
		rx_data   = '0;
		tx_ready  = 1'b0;
		vec_phase = 1'b0;
		last_sig  = '0;
		low_cnt   = 0;
		cycle_cnt = 0;
		void'($urandom(SEED));
		make_vectors();
		repeat (2) @(posedge CLK);
		rst <= 1'b0;

		// Idle outputs right after reset.
		@(negedge CLK);
		if (cs_n !== 1'b1 || counter_clk !== 1'b0 || tx_valid !== 1'b0 ||
				rx_ready !== 1'b0 || signals !== '0) begin
			$display("Outputs not idle after reset");
			fail_run();
		end

		// Bad code, then execute on an empty store.
		send_command("unknown code", {24'd0, 8'h5A});
		send_command("execute empty", {24'd0, CMD_EXECUTE});

		// Fill the store, then one header too many.
		for (int i = 0; i < DEPTH; i++) begin
			send_command($sformatf("vector %0d header", i), {24'd0, CMD_VECTOR_HDR});
			send_command($sformatf("vector %0d word", i), vec_words[i]);
		end
		send_command("header when full", {24'd0, CMD_VECTOR_HDR});

		run_and_check("default run", DEF_LEAD, DEF_TRAIL);

		// Random configuration with 0 < lead < trail < len.
		len_i     = $urandom_range(3, MAX_LEN);
		lead_i    = $urandom_range(1, len_i - 2);
		trail_i   = $urandom_range(lead_i + 1, len_i - 1);
		cfg_len   = edge_t'(len_i);
		cfg_lead  = edge_t'(lead_i);
		cfg_trail = edge_t'(trail_i);
		send_command("cycle config", {cfg_len, cfg_trail, cfg_lead, CMD_CYCLE_CONFIG});
		run_and_check("configured run", cfg_lead, cfg_trail);

		$display("*** PASSED ***");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
hw/tester_pkg.sv
hw/cmd_sequencer.sv
hw/vector_store.sv
hw/cycle_timer.sv
hw/signal_driver.sv
hw/tester_top.sv
sim/tb_tester.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build with Verilator and run; exit status follows the simulation.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_tester -f build.f -o sim_tester \
	&& ./obj_dir/sim_tester \
	|| { echo "Simulation run failed"; exit 1; }
